// ==== verilog.f ====
capture_pkg.sv
pixel_fifo.sv
rgb_logic.sv
slice_buffer.sv
video_capture_top.sv
capture_properties.sv
tb_video_capture.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_video_capture \
    -f verilog.f \
    --Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0

// ==== tb_video_capture.sv ====
`timescale 1ns/1ps

module tb_video_capture;

    import capture_pkg::*;

    // About four frames at half rate plus readbacks and some margin
    localparam int max_cycles = 40000;

    logic        clk;
    logic        nrst;
    pixel_t      cam_rgb;
    logic        cam_hsync;
    logic        cam_vsync;
    logic        cam_write;
    logic        rgb_enable;
    slice_addr_t rd_addr;
    pixel_t      rd_data;
    logic        slice_ready;
    logic        overflow;
    slice_cnt_t  slice_count;

    integer seed;
    int     cycle_count;
    int     forced_req;
    int     forced_ack;
    int     sweep_count;
    int     ready_count;

    // Slice being sent is frozen into exp_mem when slice_ready fires
    pixel_t build_mem [0:slice_pixels-1];
    pixel_t exp_mem   [0:slice_pixels-1];

    video_capture_top #(
        .fifo_depth (16)
    ) dut_i (
        .clk         (clk),
        .nrst        (nrst),
        .cam_rgb     (cam_rgb),
        .cam_hsync   (cam_hsync),
        .cam_vsync   (cam_vsync),
        .cam_write   (cam_write),
        .rgb_enable  (rgb_enable),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .slice_ready (slice_ready),
        .overflow    (overflow),
        .slice_count (slice_count)
    );

    bind video_capture_top capture_properties capture_properties_i (
        .clk         (clk),
        .nrst        (nrst),
        .slice_ready (slice_ready),
        .overflow    (overflow),
        .slice_count (slice_count),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= max_cycles) begin
                $display("Simulation timed out after %0d cycles", cycle_count);
                $display("Verification failed");
                $fatal(1, "Timeout");
            end
        end
    end

    // Expected address from the block geometry and value with its bytes reversed
    function automatic logic [34:0] expected_entry(input int idx, input pixel_t word);
        int          p_col;
        int          b_col;
        int          p_line;
        int          b_line;
        slice_addr_t addr;
        pixel_t      value;
        p_col  = idx % block_width;
        b_col  = (idx / block_width) % blocks_per_row;
        p_line = (idx / slice_width) % block_height;
        b_line = idx / (slice_width * block_height);
        addr   = slice_addr_t'((b_line * block_height + p_line) * slice_width
                               + b_col * block_width + p_col);
        value  = {word[7:0], word[15:8], word[23:16]};
        return {addr, value};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "Check failed");
    endtask

    // One camera word, then one or two idle cycles
    task automatic send_word(input pixel_t word, input logic hs, input logic vs);
        int gap;
        gap = 1 + ($random(seed) & 1);
        @(posedge clk);
        cam_rgb   <= word;
        cam_hsync <= hs;
        cam_vsync <= vs;
        cam_write <= 1'b1;
        repeat (gap) begin
            @(posedge clk);
            cam_write <= 1'b0;
        end
    endtask

    // Vsync low word, then a marker whose vsync rise opens the frame
    task automatic start_frame(input logic enable);
        send_word(pixel_t'($random(seed)), 1'b0, 1'b0);
        rgb_enable <= enable;
        send_word(pixel_t'($random(seed)), 1'b1, 1'b1);
    endtask

    task automatic send_pixels(input int count, input bit hsync_gaps, input bit store);
        pixel_t      word;
        logic [34:0] entry;
        for (int idx = 0; idx < count; idx++) begin
            // Stray word outside hsync
            if (hsync_gaps && (($random(seed) & 7) == 0)) begin
                send_word(pixel_t'($random(seed)), 1'b0, 1'b1);
            end
            word  = pixel_t'($random(seed));
            entry = expected_entry(idx, word);
            if (store) begin
                build_mem[entry[34:24]] = entry[23:0];
            end
            send_word(word, 1'b1, 1'b1);
        end
    endtask

    task automatic wait_sweeps(input int target);
        while (sweep_count < target) begin
            @(posedge clk);
        end
    endtask

    task automatic check_count(input slice_cnt_t expected);
        assert (slice_count === expected)
        else stop_on_error($sformatf("Fail at %0d ns: slice_count %0d, expected %0d",
                                     $time, slice_count, expected));
    endtask

    // Readback sweep after every slice_ready or on request
    initial begin
        rd_addr     = '0;
        forced_ack  = 0;
        sweep_count = 0;
        ready_count = 0;
        forever begin
            @(posedge clk);
            if (slice_ready === 1'b1 || forced_req != forced_ack) begin
                if (slice_ready === 1'b1) begin
                    ready_count++;
                    for (int a = 0; a < slice_pixels; a++) begin
                        exp_mem[a] = build_mem[a];
                    end
                end else begin
                    forced_ack++;
                end
                rd_addr <= '0;
                for (int i = 1; i <= slice_pixels + 1; i++) begin
                    @(posedge clk);
                    if (i >= 2) begin
                        assert (rd_data === exp_mem[i-2])
                        else stop_on_error($sformatf(
                            "Fail at %0d ns: addr %0d expected %06h got %06h",
                            $time, i - 2, exp_mem[i-2], rd_data));
                    end
                    if (i < slice_pixels) begin
                        rd_addr <= slice_addr_t'(i);
                    end
                end
                sweep_count++;
            end
        end
    end

    initial begin
        seed       = 28;
        nrst       = 1'b0;
        cam_rgb    = '0;
        cam_hsync  = 1'b0;
        cam_vsync  = 1'b0;
        cam_write  = 1'b0;
        rgb_enable = 1'b0;
        forced_req = 0;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        assert (slice_ready === 1'b0 && overflow === 1'b0 && slice_count === '0)
        else stop_on_error("Outputs were not in their reset state after reset");

        // Enabled frame with one full slice
        start_frame(1'b1);
        send_pixels(slice_pixels, 1'b0, 1'b1);
        wait_sweeps(1);
        check_count(8'd1);

        // Hsync low words in the same frame are skipped
        send_pixels(slice_pixels, 1'b1, 1'b1);
        wait_sweeps(2);
        check_count(8'd2);

        // Disabled frame is counted but never stored
        start_frame(1'b0);
        send_pixels(slice_pixels, 1'b0, 1'b0);
        repeat (4) @(posedge clk);
        check_count(8'd1);
        assert (ready_count == 2)
        else stop_on_error("slice_ready fired for a frame that was not enabled");
        forced_req++;
        wait_sweeps(3);

        // Vsync rise part way through a slice
        send_pixels(700, 1'b0, 1'b0);
        start_frame(1'b1);
        repeat (2) @(posedge clk);
        check_count(8'd0);
        send_pixels(slice_pixels, 1'b0, 1'b1);
        wait_sweeps(4);
        check_count(8'd1);

        // Burst into a stalled FIFO
        assert (overflow === 1'b0)
        else stop_on_error("overflow was set before the burst");
        force dut_i.fifo_pop = 1'b0;
        repeat (20) begin
            @(posedge clk);
            cam_rgb   <= pixel_t'($random(seed));
            cam_hsync <= 1'b0;
            cam_vsync <= 1'b0;
            cam_write <= 1'b1;
        end
        @(posedge clk);
        cam_write <= 1'b0;
        release dut_i.fifo_pop;
        repeat (24) begin
            @(posedge clk);
            assert (overflow === 1'b1)
            else stop_on_error("overflow was not set or did not stay set after the burst");
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== capture_properties.sv ====
`timescale 1ns/1ps

module capture_properties (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     slice_ready,
    input  logic                     overflow,
    input  capture_pkg::slice_cnt_t  slice_count,
    input  capture_pkg::slice_addr_t rd_addr,
    input  capture_pkg::pixel_t      rd_data
);

    // Set once a completed bank has been swapped to the read side
    logic slice_seen;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            slice_seen <= 1'b0;
        end else if (slice_ready) begin
            slice_seen <= 1'b1;
        end
    end

    ready_is_pulse: assert property (@(posedge clk) disable iff (!nrst)
        slice_ready |=> !slice_ready)
    else $error("slice_ready stayed high for two cycles");

    overflow_sticky: assert property (@(posedge clk) disable iff (!nrst)
        overflow |=> overflow)
    else $error("overflow dropped without a reset");

    // Counter moves by one or restarts at a frame start
    count_steps: assert property (@(posedge clk) disable iff (!nrst)
        (slice_count != $past(slice_count)) |->
        (slice_count == $past(slice_count) + 8'd1) || (slice_count == 8'd0))
    else $error("slice_count jumped by more than one");

    read_known: assert property (@(posedge clk) disable iff (!nrst)
        (slice_seen && !$isunknown(rd_addr)) |=> !$isunknown(rd_data))
    else $error("rd_data unknown after a known rd_addr");

endmodule

// ==== video_capture_top.sv ====
`timescale 1ns/1ps

module video_capture_top #(
    parameter int fifo_depth = 16
) (
    input  logic                     clk,
    input  logic                     nrst,
    input  capture_pkg::pixel_t      cam_rgb,
    input  logic                     cam_hsync,
    input  logic                     cam_vsync,
    input  logic                     cam_write,
    input  logic                     rgb_enable,
    input  capture_pkg::slice_addr_t rd_addr,
    output capture_pkg::pixel_t      rd_data,
    output logic                     slice_ready,
    output logic                     overflow,
    output capture_pkg::slice_cnt_t  slice_count
);

    import capture_pkg::*;

    // FIFO head
    pixel_t    fifo_rgb;
    logic      fifo_hsync;
    logic      fifo_vsync;
    logic      fifo_empty;
    logic      fifo_pop;

    // Pixel stream into the slice buffer
    pixel_t    pixel_data;
    logic      pixel_valid;
    pix_col_t  pixel_col;
    pix_line_t pixel_line;
    blk_col_t  block_col;
    blk_line_t block_line;
    logic      eos;

    // rgb_logic never stalls, so every present word is taken
    assign fifo_pop = ~fifo_empty;

    pixel_fifo #(
        .fifo_depth (fifo_depth)
    ) fifo_i (
        .clk        (clk),
        .nrst       (nrst),
        .cam_rgb    (cam_rgb),
        .cam_hsync  (cam_hsync),
        .cam_vsync  (cam_vsync),
        .cam_write  (cam_write),
        .pop        (fifo_pop),
        .fifo_rgb   (fifo_rgb),
        .fifo_hsync (fifo_hsync),
        .fifo_vsync (fifo_vsync),
        .empty      (fifo_empty),
        .overflow   (overflow)
    );

    rgb_logic rgb_logic_i (
        .clk         (clk),
        .nrst        (nrst),
        .rgb         (fifo_rgb),
        .hsync       (fifo_hsync),
        .vsync       (fifo_vsync),
        .empty       (fifo_empty),
        .rgb_enable  (rgb_enable),
        .EOS         (eos),
        .wslice_cnt  (slice_count),
        .pixel_data  (pixel_data),
        .pixel_valid (pixel_valid),
        .pixel_col   (pixel_col),
        .pixel_line  (pixel_line),
        .block_col   (block_col),
        .block_line  (block_line)
    );

    slice_buffer slice_buffer_i (
        .clk         (clk),
        .nrst        (nrst),
        .pixel_data  (pixel_data),
        .pixel_valid (pixel_valid),
        .pixel_col   (pixel_col),
        .pixel_line  (pixel_line),
        .block_col   (block_col),
        .block_line  (block_line),
        .EOS         (eos),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .slice_ready (slice_ready)
    );

endmodule

// ==== slice_buffer.sv ====
`timescale 1ns/1ps

module slice_buffer (
    input  logic                     clk,
    input  logic                     nrst,
    input  capture_pkg::pixel_t      pixel_data,
    input  logic                     pixel_valid,
    input  capture_pkg::pix_col_t    pixel_col,
    input  capture_pkg::pix_line_t   pixel_line,
    input  capture_pkg::blk_col_t    block_col,
    input  capture_pkg::blk_line_t   block_line,
    input  logic                     EOS,
    input  capture_pkg::slice_addr_t rd_addr,
    output capture_pkg::pixel_t      rd_data,
    output logic                     slice_ready
);

    import capture_pkg::*;

    // Two banks, one filled while the other is read
    pixel_t bank_mem [0:1][0:slice_pixels-1];

    logic        wr_bank;
    logic        rd_bank;
    logic [1:0]  dirty;
    logic        swap;
    logic        wr_sel;

    // Row 0..47 and column 0..39 inside the slice
    logic [5:0]  pix_row;
    logic [5:0]  pix_x;
    slice_addr_t wr_addr;

    assign pix_row = 6'(block_line) * 6'(block_height) + 6'(pixel_line);
    assign pix_x   = 6'(block_col) * 6'(block_width) + 6'(pixel_col);
    assign wr_addr = slice_addr_t'(pix_row) * slice_addr_t'(slice_width)
                   + slice_addr_t'(pix_x);

    // An empty slice leaves the last good one readable
    assign swap = EOS & dirty[wr_bank];

    // A pixel arriving on the swap edge already belongs to the next slice
    assign wr_sel  = swap ? ~wr_bank : wr_bank;
    assign rd_bank = ~wr_bank;

    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            bank_mem[wr_sel][wr_addr] <= pixel_data;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_bank     <= 1'b0;
            dirty       <= '0;
            slice_ready <= 1'b0;
        end else begin
            slice_ready <= swap;
            if (swap) begin
                wr_bank         <= ~wr_bank;
                dirty[~wr_bank] <= pixel_valid;
            end else if (pixel_valid) begin
                dirty[wr_bank] <= 1'b1;
            end
        end
    end

    // Registered readout of the completed bank
    always_ff @(posedge clk) begin
        rd_data <= bank_mem[rd_bank][rd_addr];
    end

endmodule

// ==== rgb_logic.sv ====
`timescale 1ns/1ps

module rgb_logic (
    input  logic                    clk,
    input  logic                    nrst,
    input  capture_pkg::pixel_t     rgb,
    input  logic                    hsync,
    input  logic                    vsync,
    input  logic                    empty,
    input  logic                    rgb_enable,
    output logic                    EOS,
    output capture_pkg::slice_cnt_t wslice_cnt,
    output capture_pkg::pixel_t     pixel_data,
    output logic                    pixel_valid,
    output capture_pkg::pix_col_t   pixel_col,
    output capture_pkg::pix_line_t  pixel_line,
    output capture_pkg::blk_col_t   block_col,
    output capture_pkg::blk_line_t  block_line
);

    import capture_pkg::*;

    logic vsync_r;
    logic frame_enable;
    logic frame_start;
    logic advance;

    // Vsync rise between two consumed words
    assign frame_start = ~empty & vsync & ~vsync_r;

    // Only words inside both syncs move the counters
    assign advance = ~empty & hsync & vsync;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            vsync_r <= 1'b0;
        end else if (!empty) begin
            vsync_r <= vsync;
        end
    end

    // Enable is sampled once per frame
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            frame_enable <= 1'b0;
        end else if (frame_start) begin
            frame_enable <= rgb_enable;
        end
    end

    // Nested coordinate counters, innermost is the column in the block
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pixel_col  <= '0;
            pixel_line <= '0;
            block_col  <= '0;
            block_line <= '0;
            wslice_cnt <= '0;
            EOS        <= 1'b0;
        end else begin
            EOS <= 1'b0;
            if (frame_start) begin
                pixel_col  <= '0;
                pixel_line <= '0;
                block_col  <= '0;
                block_line <= '0;
                wslice_cnt <= '0;
            end else if (advance) begin
                pixel_col <= pixel_col + 1'b1;
                if (pixel_col == pix_col_t'(block_width - 1)) begin
                    pixel_col <= '0;
                    block_col <= block_col + 1'b1;
                    if (block_col == blk_col_t'(blocks_per_row - 1)) begin
                        block_col  <= '0;
                        pixel_line <= pixel_line + 1'b1;
                        if (pixel_line == pix_line_t'(block_height - 1)) begin
                            pixel_line <= '0;
                            block_line <= block_line + 1'b1;
                            // Last pixel of the slice
                            if (block_line == blk_line_t'(block_rows - 1)) begin
                                block_line <= '0;
                                wslice_cnt <= wslice_cnt + 1'b1;
                                EOS        <= 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    // The word carrying the vsync rise only marks the frame and is not stored
    assign pixel_valid = frame_enable & hsync & vsync & ~empty & ~frame_start;

    // Byte order reversed, first input byte ends up last
    assign pixel_data = {<<8{rgb}};

endmodule

// ==== pixel_fifo.sv ====
`timescale 1ns/1ps

module pixel_fifo #(
    parameter int fifo_depth = 16
) (
    input  logic                clk,
    input  logic                nrst,
    input  capture_pkg::pixel_t cam_rgb,
    input  logic                cam_hsync,
    input  logic                cam_vsync,
    input  logic                cam_write,
    input  logic                pop,
    output capture_pkg::pixel_t fifo_rgb,
    output logic                fifo_hsync,
    output logic                fifo_vsync,
    output logic                empty,
    output logic                overflow
);

    import capture_pkg::*;

    localparam int ptr_w   = $clog2(fifo_depth);
    localparam int entry_w = $bits(pixel_t) + 2;

    // Entry layout is {vsync, hsync, rgb}
    logic [entry_w-1:0] fifo_mem [0:fifo_depth-1];
    logic [entry_w-1:0] head;

    // Pointers carry an extra wrap bit to tell full from empty
    logic [ptr_w:0] wr_ptr;
    logic [ptr_w:0] rd_ptr;
    logic           full;
    logic           do_write;
    logic           do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
                   (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);

    // A write while full is lost, even when a pop happens in the same cycle
    assign do_write = cam_write & ~full;
    assign do_pop   = pop & ~empty;

    always_ff @(posedge clk) begin
        if (do_write) begin
            fifo_mem[wr_ptr[ptr_w-1:0]] <= {cam_vsync, cam_hsync, cam_rgb};
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Sticky until reset
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            overflow <= 1'b0;
        end else if (cam_write && full) begin
            overflow <= 1'b1;
        end
    end

    // First word falls through to the outputs
    assign head       = fifo_mem[rd_ptr[ptr_w-1:0]];
    assign fifo_rgb   = head[$bits(pixel_t)-1:0];
    assign fifo_hsync = head[$bits(pixel_t)];
    assign fifo_vsync = head[$bits(pixel_t)+1];

endmodule

// ==== capture_pkg.sv ====
package capture_pkg;

    // One RGB pixel as delivered by the sensor
    typedef logic [23:0] pixel_t;

    // Position of a pixel inside its micro-block
    typedef logic [2:0] pix_col_t;
    typedef logic [3:0] pix_line_t;

    // Position of the micro-block inside the slice
    typedef logic [2:0] blk_col_t;
    typedef logic [1:0] blk_line_t;

    // Completed slices since reset or frame start
    typedef logic [7:0] slice_cnt_t;

    // Linear pixel address inside one slice
    typedef logic [10:0] slice_addr_t;

    // Slice geometry, fixed by the counter widths above
    localparam int block_width    = 8;
    localparam int block_height   = 16;
    localparam int blocks_per_row = 5;
    localparam int block_rows     = 3;
    localparam int slice_width    = block_width * blocks_per_row;
    localparam int slice_pixels   = slice_width * block_height * block_rows;

endpackage
